// ==== adc_capture_top.f ====
+incdir+.
adc_capture_pkg.sv
capture_ctrl.sv
host_regs.sv
ram_arbiter.sv
capture_ram.sv
adc_capture_top.sv
tb_adc_capture_sva.sv
tb_adc_capture.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the capture core testbench with Verilator, runs it and looks for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_adc_capture -f adc_capture_top.f -o sim_adc_capture

status=0
out=$(./obj_dir/sim_adc_capture 2>&1) || status=$?
printf '%s\n' "$out"

if [ "$status" -eq 0 ] && printf '%s\n' "$out" | grep -qx 'Result: PASSED'; then
	exit 0
fi
exit 1

// ==== tb_adc_capture.sv ====
// testbench for the capture core: register table, full and early-stopped captures, host reads
`timescale 1ns/1ps
`include "adc_capture_consts.svh"

module tb_adc_capture;

	localparam int RVALID_TIMEOUT = 4000;
	localparam int DONE_POLLS = 2000;
	localparam logic [`HOST_ADDR_W-1:0] CTRL_ADDR = `HOST_ADDR_W'(`REG_CTRL);
	localparam logic [`HOST_ADDR_W-1:0] STATUS_ADDR = `HOST_ADDR_W'(`REG_STATUS);

	typedef struct packed {
		logic wr;
		logic [`HOST_ADDR_W-1:0] addr;
		logic [`HOST_DATA_W-1:0] wdata;
		logic [`HOST_DATA_W-1:0] expected;
	} reg_op_t;

	logic data_clk_div;
	logic rst_n;
	adc_capture_pkg::adc_sample_t samples;
	adc_capture_pkg::host_req_t host;
	logic [`HOST_DATA_W-1:0] host_rdata;
	logic host_rvalid;
	logic [`ADC_SAMPLE_W-1:0] n;
	int tests;
	int failures;

	// rows 0 and 1 read the reset values
	// rows 2 to 7 write control and read it back
	reg_op_t reg_ops [8] = '{
		'{1'b0, CTRL_ADDR, 32'h0, 32'h0},
		'{1'b0, STATUS_ADDR, 32'h0, 32'h0},
		'{1'b1, CTRL_ADDR, 32'ha5a5_a5a1, 32'h0},
		'{1'b0, CTRL_ADDR, 32'h0, 32'ha5a5_a5a1},
		'{1'b1, CTRL_ADDR, 32'h5a5a_5a59, 32'h0},
		'{1'b0, CTRL_ADDR, 32'h0, 32'h5a5a_5a59},
		'{1'b1, CTRL_ADDR, 32'h0, 32'h0},
		'{1'b0, STATUS_ADDR, 32'h0, 32'h0}
	};

	adc_capture_top dut (
		.data_clk_div (data_clk_div),
		.rst_n        (rst_n),
		.samples      (samples),
		.host         (host),
		.host_rdata   (host_rdata),
		.host_rvalid  (host_rvalid)
	);

	always #2 data_clk_div = ~data_clk_div;

	// ch0 counts up each cycle and ch1 mirrors it
	always @(posedge data_clk_div) begin
		n <= n + 1'b1;
		samples.ch0 <= n;
		samples.ch1 <= ~n;
	end

	function automatic logic [`HOST_ADDR_W-1:0] mem_addr(input int idx);
		return `HOST_ADDR_W'(`CAP_DEPTH + idx);
	endfunction

	task automatic timeout_abort(input string why);
		$display("timeout: %s", why);
		$display("Result: FAILED");
		$finish;
	endtask

	task automatic finish_test(input string name, input int errs);
		tests++;
		if (errs != 0) begin
			failures++;
			$display("test %s: bad, %0d errors", name, errs);
		end else begin
			$display("test %s: ok", name);
		end
	endtask

	task automatic host_write(input logic [`HOST_ADDR_W-1:0] addr, input logic [31:0] data);
		@(posedge data_clk_div);
		host.wr <= 1'b1;
		host.addr <= addr;
		host.wdata <= data;
		@(posedge data_clk_div);
		host <= '0;
	endtask

	task automatic host_read(input logic [`HOST_ADDR_W-1:0] addr, output logic [31:0] data);
		int cycles;
		cycles = 0;
		@(posedge data_clk_div);
		host.rd <= 1'b1;
		host.addr <= addr;
		@(posedge data_clk_div);
		host <= '0;
		@(negedge data_clk_div);
		while (!host_rvalid && cycles < RVALID_TIMEOUT) begin
			@(negedge data_clk_div);
			cycles++;
		end
		if (!host_rvalid) begin
			timeout_abort($sformatf("no host_rvalid for read of 0x%03h", addr));
		end else begin
			data = host_rdata;
		end
	endtask

	task automatic run_reg_ops(input int first, input int last, input string name);
		logic [31:0] rd;
		int errs;
		errs = 0;
		for (int i = first; i <= last; i++) begin
			if (reg_ops[i].wr) begin
				host_write(reg_ops[i].addr, reg_ops[i].wdata);
			end else begin
				host_read(reg_ops[i].addr, rd);
				if (rd !== reg_ops[i].expected) begin
					$display("[ERROR] host_rdata at 0x%03h = 0x%08h, expected 0x%08h",
						reg_ops[i].addr, rd, reg_ops[i].expected);
					errs++;
				end
			end
		end
		finish_test(name, errs);
	endtask

	// polls status until done comes up
	task automatic wait_done(output logic [31:0] status);
		int polls;
		polls = 0;
		host_read(STATUS_ADDR, status);
		while (!status[1] && polls < DONE_POLLS) begin
			host_read(STATUS_ADDR, status);
			polls++;
		end
		if (!status[1]) begin
			timeout_abort("done never set after a full capture");
		end
	endtask

	task automatic check_words(input int count, inout int errs, output logic [15:0] first_ch0);
		adc_capture_pkg::cap_word_u word;
		adc_capture_pkg::cap_word_u prev;
		prev = '0;
		first_ch0 = '0;
		for (int i = 0; i < count; i++) begin
			host_read(mem_addr(i), word.raw);
			if (word.pair.ch1 !== ~word.pair.ch0) begin
				$display("[ERROR] mem[0x%03h].ch1 = 0x%04h, expected 0x%04h",
					i, word.pair.ch1, ~word.pair.ch0);
				errs++;
			end
			if (i == 0) begin
				first_ch0 = word.pair.ch0;
			end else if (word.pair.ch0 !== prev.pair.ch0 + 16'd1) begin
				$display("[ERROR] mem[0x%03h].ch0 = 0x%04h, expected 0x%04h",
					i, word.pair.ch0, prev.pair.ch0 + 16'd1);
				errs++;
			end
			prev = word;
		end
	endtask

	initial begin
		logic [31:0] rd;
		logic [31:0] early_read;
		logic [31:0] status;
		logic [`HOST_ADDR_W-1:0] probe_addr;
		logic [15:0] full_first;
		logic [15:0] early_first;
		int errs;
		int delay;
		int count;
		int sva_fails;

		void'($urandom(32'h14bc_e012));
		data_clk_div = 1'b0;
		rst_n = 1'b0;
		samples = '0;
		host = '0;
		n = '0;
		tests = 0;
		failures = 0;
		repeat (10) @(posedge data_clk_div);
		rst_n <= 1'b1;

		run_reg_ops(0, 1, "reset values");
		run_reg_ops(2, 7, "control readback");

		// full capture with a memory read that has to wait for the writer
		errs = 0;
		probe_addr = mem_addr(int'($urandom % `CAP_DEPTH));
		host_write(CTRL_ADDR, 32'h1 << `CTRL_CAPTURE_BIT);
		repeat (20) @(posedge data_clk_div);
		host_read(probe_addr, early_read);
		wait_done(status);
		if (status !== 32'h0400_0002) begin
			$display("[ERROR] status = 0x%08h, expected 0x04000002", status);
			errs++;
		end
		check_words(`CAP_DEPTH, errs, full_first);
		finish_test("full capture", errs);

		errs = 0;
		host_read(probe_addr, rd);
		if (rd !== early_read) begin
			$display("[ERROR] host_rdata at 0x%03h = 0x%08h, expected 0x%08h",
				probe_addr, early_read, rd);
			errs++;
		end
		finish_test("read during capture", errs);

		errs = 0;
		host_write(CTRL_ADDR, 32'h1 << `CTRL_CLEAR_BIT);
		host_read(STATUS_ADDR, rd);
		if (rd !== 32'h0) begin
			$display("[ERROR] status = 0x%08h, expected 0x00000000", rd);
			errs++;
		end
		finish_test("soft clear", errs);

		// early stop after a random delay
		errs = 0;
		delay = 50 + int'($urandom % 400);
		host_write(CTRL_ADDR, 32'h1 << `CTRL_CAPTURE_BIT);
		repeat (delay) @(posedge data_clk_div);
		host_write(CTRL_ADDR, 32'h0);
		host_read(STATUS_ADDR, status);
		count = int'(status[26:16]);
		if (status[1:0] !== 2'b00) begin
			$display("[ERROR] status[1:0] = 0x%0h, expected 0x0", status[1:0]);
			errs++;
		end
		if (count == 0 || count >= `CAP_DEPTH) begin
			$display("[ERROR] word_count = 0x%03h, expected 0x001 to 0x3ff", count);
			errs++;
		end else begin
			check_words(count, errs, early_first);
			if (early_first === full_first) begin
				$display("[ERROR] mem[0x000].ch0 = 0x%04h, expected other than 0x%04h",
					early_first, full_first);
				errs++;
			end
		end
		finish_test("early stop", errs);

		sva_fails = dut.u_capture_ctrl.ctrl_sva.fail_count
			+ dut.u_ram_arbiter.arb_sva.fail_count;
		$display("tests %0d, failed %0d, assertion failures %0d", tests, failures, sva_fails);
		if (failures == 0 && sva_fails == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

// ==== tb_adc_capture_sva.sv ====
// concurrent checks on the capture writer and the memory arbiter, bound into both
`timescale 1ns/1ps
`include "adc_capture_consts.svh"

module adc_capture_sva #(
	parameter bit CHECK_GRANT = 1'b1,
	parameter bit CHECK_COUNT = 1'b1
) (
	input logic                 data_clk_div,
	input logic                 rst_n,
	input logic                 wr_active,
	input logic                 rd_grant,
	input logic                 done,
	input logic [`CAP_ADDR_W:0] word_count
);

	int fail_count = 0;

	generate
		if (CHECK_GRANT) begin : g_grant
			// the host read slot never lands on a cycle the writer wants
			no_grant_over_writer: assert property (@(posedge data_clk_div) disable iff (!rst_n)
				rd_grant |-> !wr_active)
			else begin
				fail_count++;
				$error("host read granted while the writer requested the memory");
			end
		end

		if (CHECK_COUNT) begin : g_count
			count_in_range: assert property (@(posedge data_clk_div) disable iff (!rst_n)
				word_count <= `CAP_DEPTH)
			else begin
				fail_count++;
				$error("word_count 0x%03h is past the memory depth", word_count);
			end

			done_only_when_full: assert property (@(posedge data_clk_div) disable iff (!rst_n)
				done |-> (word_count == `CAP_DEPTH))
			else begin
				fail_count++;
				$error("done set with word_count 0x%03h", word_count);
			end
		end
	endgenerate

endmodule

bind capture_ctrl adc_capture_sva #(
	.CHECK_GRANT (1'b0),
	.CHECK_COUNT (1'b1)
) ctrl_sva (
	.data_clk_div (data_clk_div),
	.rst_n        (rst_n),
	.wr_active    (wr_req.req),
	.rd_grant     (1'b0),
	.done         (done),
	.word_count   (word_count)
);

bind ram_arbiter adc_capture_sva #(
	.CHECK_GRANT (1'b1),
	.CHECK_COUNT (1'b0)
) arb_sva (
	.data_clk_div (data_clk_div),
	.rst_n        (rst_n),
	.wr_active    (wr_req.req),
	.rd_grant     (rd_grant),
	.done         (1'b0),
	.word_count   (11'd0)
);

// ==== adc_capture_top.sv ====
// top of the capture core: writer, host registers, arbiter and memory wired together
`timescale 1ns/1ps
`include "adc_capture_consts.svh"

module adc_capture_top (
	input  logic                         data_clk_div,
	input  logic                         rst_n,
	input  adc_capture_pkg::adc_sample_t samples,
	input  adc_capture_pkg::host_req_t   host,
	output logic [`HOST_DATA_W-1:0]      host_rdata,
	output logic                         host_rvalid
);

	adc_capture_pkg::ram_req_t wr_req;
	adc_capture_pkg::ram_req_t rd_req;
	adc_capture_pkg::ram_req_t ram_req;
	adc_capture_pkg::cap_word_u ram_rdata;
	logic rd_grant;
	logic capture_enable;
	logic capture_clear;
	logic capturing;
	logic done;
	logic [`CAP_ADDR_W:0] word_count;

	capture_ctrl u_capture_ctrl (
		.data_clk_div   (data_clk_div),
		.rst_n          (rst_n),
		.samples        (samples),
		.capture_enable (capture_enable),
		.capture_clear  (capture_clear),
		.wr_req         (wr_req),
		.capturing      (capturing),
		.done           (done),
		.word_count     (word_count)
	);

	host_regs u_host_regs (
		.data_clk_div   (data_clk_div),
		.rst_n          (rst_n),
		.host           (host),
		.capturing      (capturing),
		.done           (done),
		.word_count     (word_count),
		.rd_grant       (rd_grant),
		.ram_rdata      (ram_rdata),
		.rd_req         (rd_req),
		.capture_enable (capture_enable),
		.capture_clear  (capture_clear),
		.host_rdata     (host_rdata),
		.host_rvalid    (host_rvalid)
	);

	ram_arbiter u_ram_arbiter (
		.data_clk_div (data_clk_div),
		.rst_n        (rst_n),
		.wr_req       (wr_req),
		.rd_req       (rd_req),
		.rd_grant     (rd_grant),
		.ram_req      (ram_req)
	);

	capture_ram u_capture_ram (
		.data_clk_div (data_clk_div),
		.ram_req      (ram_req),
		.rdata        (ram_rdata)
	);

endmodule

// ==== capture_ram.sv ====
// single-port capture memory, written by the capture path and read back by the host
`timescale 1ns/1ps
`include "adc_capture_consts.svh"

module capture_ram (
	input  logic                       data_clk_div,
	input  adc_capture_pkg::ram_req_t  ram_req,
	output adc_capture_pkg::cap_word_u rdata
);

	adc_capture_pkg::cap_word_u mem [`CAP_DEPTH];

	// read data lands one cycle after the request
	always_ff @(posedge data_clk_div) begin
		if (ram_req.req) begin
			if (ram_req.we) begin
				mem[ram_req.addr] <= ram_req.wdata;
			end else begin
				rdata <= mem[ram_req.addr];
			end
		end
	end

endmodule

// ==== ram_arbiter.sv ====
// shares the one capture memory port between the writer and the host reader
`timescale 1ns/1ps

module ram_arbiter (
	input  logic                      data_clk_div,
	input  logic                      rst_n,
	input  adc_capture_pkg::ram_req_t wr_req,
	input  adc_capture_pkg::ram_req_t rd_req,
	output logic                      rd_grant,
	output adc_capture_pkg::ram_req_t ram_req
);

	logic host_win;

	// writer has fixed priority and is never held off
	// rd_grant masks the request that is already on its way
	assign host_win = rd_req.req && !wr_req.req && !rd_grant;

	// the winner is registered onto the memory port,
	// rd_grant marks the cycle the host read is presented
	always_ff @(posedge data_clk_div) begin
		if (!rst_n) begin
			ram_req.req <= 1'b0;
			ram_req.we <= 1'b0;
			rd_grant <= 1'b0;
		end else begin
			ram_req.req <= wr_req.req || host_win;
			ram_req.we <= wr_req.req ? wr_req.we : rd_req.we;
			rd_grant <= host_win;
		end

		if (wr_req.req) begin
			ram_req.addr <= wr_req.addr;
			ram_req.wdata <= wr_req.wdata;
		end else begin
			ram_req.addr <= rd_req.addr;
			ram_req.wdata <= rd_req.wdata;
		end
	end

endmodule

// ==== host_regs.sv ====
// host side: register decode, control and status words, and host reads of the capture memory
`timescale 1ns/1ps
`include "adc_capture_consts.svh"

module host_regs (
	input  logic                       data_clk_div,
	input  logic                       rst_n,
	input  adc_capture_pkg::host_req_t host,
	input  logic                       capturing,
	input  logic                       done,
	input  logic [`CAP_ADDR_W:0]       word_count,
	input  logic                       rd_grant,
	input  adc_capture_pkg::cap_word_u ram_rdata,
	output adc_capture_pkg::ram_req_t  rd_req,
	output logic                       capture_enable,
	output logic                       capture_clear,
	output logic [`HOST_DATA_W-1:0]    host_rdata,
	output logic                       host_rvalid
);

	logic is_mem;
	logic is_ctrl;
	logic reg_rd;
	logic mem_rd;
	logic [`HOST_DATA_W-1:0] ctrl_reg;
	logic [`HOST_DATA_W-1:0] status_word;
	logic [`HOST_DATA_W-1:0] reg_mux;
	logic [`HOST_DATA_W-1:0] reg_rdata;
	logic rd_from_mem;
	logic pending;
	logic [`CAP_ADDR_W-1:0] pend_addr;

	// address bit 10 picks the memory window
	assign is_mem = host.addr[`HOST_ADDR_W-1];
	assign is_ctrl = !is_mem && (host.addr == `HOST_ADDR_W'(`REG_CTRL));
	assign reg_rd = host.rd && !is_mem;
	assign mem_rd = host.rd && is_mem;

	assign capture_enable = ctrl_reg[`CTRL_CAPTURE_BIT];

	always_comb begin
		status_word = '0;
		status_word[0] = capturing;
		status_word[1] = done;
		status_word[26:16] = word_count;
	end

	always_comb begin
		case (host.addr)
			`HOST_ADDR_W'(`REG_CTRL):   reg_mux = ctrl_reg;
			`HOST_ADDR_W'(`REG_STATUS): reg_mux = status_word;
			default:                    reg_mux = '0;
		endcase
	end

	always_ff @(posedge data_clk_div) begin
		if (!rst_n) begin
			ctrl_reg <= '0;
			capture_clear <= 1'b0;
			host_rvalid <= 1'b0;
			rd_from_mem <= 1'b0;
			pending <= 1'b0;
		end else begin
			capture_clear <= host.wr && is_ctrl && host.wdata[`CTRL_CLEAR_BIT];
			if (host.wr && is_ctrl) begin
				ctrl_reg <= host.wdata;
			end

			// memory data shows up the cycle after the grant
			host_rvalid <= reg_rd || rd_grant;

			if (reg_rd) begin
				rd_from_mem <= 1'b0;
			end else if (rd_grant) begin
				rd_from_mem <= 1'b1;
			end

			// memory read waits here until the arbiter lets it through
			if (mem_rd) begin
				pending <= 1'b1;
			end else if (rd_grant) begin
				pending <= 1'b0;
			end
		end
	end

	always_ff @(posedge data_clk_div) begin
		if (reg_rd) begin
			reg_rdata <= reg_mux;
		end
		if (mem_rd) begin
			pend_addr <= host.addr[`CAP_ADDR_W-1:0];
		end
	end

	always_comb begin
		rd_req = '0;
		rd_req.req = pending;
		rd_req.addr = pend_addr;
	end

	assign host_rdata = rd_from_mem ? ram_rdata.raw : reg_rdata;

endmodule

// ==== capture_ctrl.sv ====
// capture writer: follows the capture enable and fills the memory one word per cycle
`timescale 1ns/1ps
`include "adc_capture_consts.svh"

module capture_ctrl (
	input  logic                         data_clk_div,
	input  logic                         rst_n,
	input  adc_capture_pkg::adc_sample_t samples,
	input  logic                         capture_enable,
	input  logic                         capture_clear,
	output adc_capture_pkg::ram_req_t    wr_req,
	output logic                         capturing,
	output logic                         done,
	output logic [`CAP_ADDR_W:0]         word_count
);

	localparam logic [`CAP_ADDR_W:0] LAST_WORD = `CAP_DEPTH - 1;

	logic enable_r;
	logic enable_rise;
	logic enable_fall;
	logic last_word;

	assign enable_rise = capture_enable && !enable_r;
	assign enable_fall = !capture_enable && enable_r;
	assign last_word = (word_count == LAST_WORD);

	always_ff @(posedge data_clk_div) begin
		if (!rst_n) begin
			enable_r <= 1'b0;
			capturing <= 1'b0;
			done <= 1'b0;
			word_count <= '0;
		end else begin
			enable_r <= capture_enable;

			// a word goes out every capturing cycle, so count it
			if (capturing) begin
				word_count <= word_count + 1'b1;
				if (last_word) begin
					capturing <= 1'b0;
					done <= 1'b1;
				end
			end

			if (enable_fall) begin
				capturing <= 1'b0;
			end

			// new capture restarts at word 0
			if (enable_rise) begin
				capturing <= 1'b1;
				done <= 1'b0;
				word_count <= '0;
			end

			if (capture_clear) begin
				word_count <= '0;
				done <= 1'b0;
			end
		end
	end

	// count doubles as the write address
	always_comb begin
		wr_req = '0;
		wr_req.req = capturing;
		wr_req.we = capturing;
		wr_req.addr = word_count[`CAP_ADDR_W-1:0];
		wr_req.wdata.pair = samples;
	end

endmodule

// ==== adc_capture_pkg.sv ====
// shared types of the capture core, referenced by scoped name from every module
`include "adc_capture_consts.svh"

package adc_capture_pkg;

	// one pair of channel samples, ch0 in the upper half
	typedef struct packed {
		logic [`ADC_SAMPLE_W-1:0] ch0;
		logic [`ADC_SAMPLE_W-1:0] ch1;
	} adc_sample_t;

	// a memory word: raw for the host, pair for the writer
	typedef union packed {
		logic [`HOST_DATA_W-1:0] raw;
		adc_sample_t pair;
	} cap_word_u;

	// request to the shared memory port, held until granted
	typedef struct packed {
		logic req;
		logic we;
		logic [`CAP_ADDR_W-1:0] addr;
		cap_word_u wdata;
	} ram_req_t;

	// host bus, wr and rd are one-cycle strobes
	typedef struct packed {
		logic wr;
		logic rd;
		logic [`HOST_ADDR_W-1:0] addr;
		logic [`HOST_DATA_W-1:0] wdata;
	} host_req_t;

endpackage

// ==== adc_capture_consts.svh ====
// widths, capture depth and host register map, included by the package and the RTL
`ifndef ADC_CAPTURE_CONSTS_SVH
`define ADC_CAPTURE_CONSTS_SVH

// one ADC channel sample
`define ADC_SAMPLE_W 16

// capture memory
`define CAP_ADDR_W 10
`define CAP_DEPTH 1024

// host bus
`define HOST_ADDR_W 11
`define HOST_DATA_W 32

// register addresses, used when host address bit 10 is clear
`define REG_CTRL 0
`define REG_STATUS 1

// control register bits
`define CTRL_CAPTURE_BIT 1
`define CTRL_CLEAR_BIT 2

// status word layout
// bit 0 capturing, bit 1 done, bits 26:16 word count

`endif
